/* sim/ex_cases.txt */
# inst pc rs1 rs2 | expected: we wdata jump target, all hex
fff08193 00001000 00000005 00000000 1 00000004 0 00000000 addi -1
40008193 00001000 00000010 12345678 1 00000410 0 00000000 addi bit 30
fff0a193 00001000 00000005 00000000 1 00000000 0 00000000 slti -1
fff0b193 00001000 00000005 00000000 1 00000001 0 00000000 sltiu -1
0f00c193 00001000 12345678 00000000 1 12345688 0 00000000 xori
ff00e193 00001000 00000005 00000000 1 fffffff5 0 00000000 ori -16
7ff0f193 00001000 abcde123 00000000 1 00000123 0 00000000 andi
00409193 00001000 8000000f 00000000 1 000000f0 0 00000000 slli 4
0040d193 00001000 f0000000 00000000 1 0f000000 0 00000000 srli 4
4040d193 00001000 f0000000 00000000 1 ff000000 0 00000000 srai 4
002081b3 00001000 7fffffff 00000001 1 80000000 0 00000000 add
402081b3 00001000 00000003 00000005 1 fffffffe 0 00000000 sub
002091b3 00001000 00000001 00000021 1 00000002 0 00000000 sll low bits
0020a1b3 00001000 ffffffff 00000001 1 00000001 0 00000000 slt
0020b1b3 00001000 ffffffff 00000001 1 00000000 0 00000000 sltu
0020c1b3 00001000 ff00ff00 0ff00ff0 1 f0f0f0f0 0 00000000 xor
0020d1b3 00001000 80000000 0000003f 1 00000001 0 00000000 srl 31
4020d1b3 00001000 80000000 0000003f 1 ffffffff 0 00000000 sra 31
0020e1b3 00001000 000000f0 0000000f 1 000000ff 0 00000000 or
0020f1b3 00001000 f0f0f0f0 ffff0000 1 f0f00000 0 00000000 and
022081b3 00001000 00000003 00000005 0 00000000 0 00000000 mul rejected
00208863 00001000 00000055 00000055 0 00000000 1 00001010 beq taken
00209863 00001000 00000055 00000055 0 00000000 0 00000000 bne not taken
fe20cce3 00001000 ffffffff 00000001 0 00000000 1 00000ff8 blt -8 taken
0020d863 00001000 ffffffff 00000001 0 00000000 0 00000000 bge not taken
0020e863 00001000 00000001 80000000 0 00000000 1 00001010 bltu taken
fe20fce3 00001000 ffffffff 00000001 0 00000000 1 00000ff8 bgeu -8 taken
100000ef 00002000 00000000 00000000 1 00002004 1 00002100 jal +256
ffdff0ef 00002000 00000000 00000000 1 00002004 1 00001ffc jal -4
011080e7 00002000 00003000 00000000 1 00002004 1 00003010 jalr bit 0
123451b7 00002000 00000000 00000000 1 12345000 0 00000000 lui
fffff197 00002000 00000000 00000000 1 00001000 0 00000000 auipc
0000a183 00002000 00000004 00000000 0 00000000 0 00000000 lw dropped

/* vlog.f */
+incdir+logic
logic/rv_ex_pkg.sv
logic/int_alu.sv
logic/branch_unit.sv
logic/ex_stage.sv
sim/clk_gen.sv
sim/tb_ex_stage.sv

/* sim/tb_ex_stage.sv */
// Testbench for the execute stage.
// Runs directed cases from sim/ex_cases.txt, one idle cycle, then
// back-to-back random ALU and branch words. Each result is checked one
// cycle after its instruction is driven.

`timescale 1ns/1ps

module tb_ex_stage;

    localparam int RAND_CASES = 40;
    localparam int CLK_NS     = 8;

    logic        clk;
    logic        rst_n;
    logic        inst_valid;
    logic [31:0] inst;
    logic [31:0] pc;
    logic [31:0] rs1;
    logic [31:0] rs2;
    logic        ex_valid;
    logic        rd_we;
    logic [31:0] rd_wdata;
    logic        jump;
    logic [31:0] jump_addr;

    logic [7:0][31:0] case_q[$];    // [7] inst down to [0] target
    logic             loaded;
    int               pass_cnt;
    int               fail_cnt;
    int               test_checks;
    int               test_fail;
    integer           seed;

    clk_gen #(.PERIOD_NS(CLK_NS), .RST_CYCLES(5)) u_clk_gen (.clk(clk), .rst_n_o(rst_n));

    ex_stage dut_i (
        .clk          (clk),
        .rst_n_i      (rst_n),
        .inst_valid_i (inst_valid),
        .inst_i       (inst),
        .pc_i         (pc),
        .rs1_data_i   (rs1),
        .rs2_data_i   (rs2),
        .ex_valid_o   (ex_valid),
        .rd_we_o      (rd_we),
        .rd_wdata_o   (rd_wdata),
        .jump_o       (jump),
        .jump_addr_o  (jump_addr)
    );

    task automatic load_cases();
        int          fd;
        int          n;
        string       line;
        logic [31:0] f[8];
        fd = $fopen("sim/ex_cases.txt", "r");
        if (fd == 0) begin
            $display("Cannot open sim/ex_cases.txt, no directed cases were run");
            fail_cnt++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n == 0 || line.len() < 8 || line.getc(0) == "#") begin
                continue;                   // blank or header line
            end
            n = $sscanf(line, "%h %h %h %h %h %h %h %h",
                        f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7]);
            if (n != 8) begin
                $display("Malformed line in the case file: %s", line);
                fail_cnt++;
            end else begin
                case_q.push_back({f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7]});
            end
        end
        $fclose(fd);
    endtask

    task automatic drive(input logic v, input logic [31:0] w, input logic [31:0] p,
                         input logic [31:0] a, input logic [31:0] b);
        inst_valid = v;
        inst       = w;
        pc         = p;
        rs1        = a;
        rs2        = b;
    endtask

    task automatic tally(input int bad);
        test_checks++;
        if (bad == 0) begin
            pass_cnt++;
        end else begin
            fail_cnt++;
            test_fail++;
        end
    endtask

    task automatic end_test(input string name);
        $display("test %-9s %0d checks, %0d failed", name, test_checks, test_fail);
        test_checks = 0;
        test_fail   = 0;
    endtask

    task automatic check_out(input string name, input logic exp_we, input logic [31:0] exp_wd,
                             input logic exp_jump, input logic [31:0] exp_tgt);
        int bad;
        bad = 0;
        if (ex_valid !== 1'b1) begin
            $display("** Error at %0d ns: %s ex_valid_o=%b, expected 1", $time, name, ex_valid);
            bad++;
        end
        if (rd_we !== exp_we) begin
            $display("** Error at %0d ns: %s rd_we_o=%b, expected %b", $time, name, rd_we, exp_we);
            bad++;
        end
        if (exp_we && rd_wdata !== exp_wd) begin
            $display("** Error at %0d ns: %s rd_wdata_o=%h, expected %h",
                     $time, name, rd_wdata, exp_wd);
            bad++;
        end
        if (jump !== exp_jump) begin
            $display("** Error at %0d ns: %s jump_o=%b, expected %b", $time, name, jump, exp_jump);
            bad++;
        end
        if (exp_jump && jump_addr !== exp_tgt) begin
            $display("** Error at %0d ns: %s jump_addr_o=%h, expected %h",
                     $time, name, jump_addr, exp_tgt);
            bad++;
        end
        tally(bad);
    endtask

    // controls low, data outputs unchanged
    task automatic check_idle(input string name, input logic [31:0] wd, input logic [31:0] tgt);
        int bad;
        bad = 0;
        if (ex_valid !== 1'b0 || rd_we !== 1'b0 || jump !== 1'b0) begin
            $display("** Error at %0d ns: %s controls valid/we/jump=%b%b%b, expected 000",
                     $time, name, ex_valid, rd_we, jump);
            bad++;
        end
        if (rd_wdata !== wd || jump_addr !== tgt) begin
            $display("** Error at %0d ns: %s data %h/%h, expected %h/%h",
                     $time, name, rd_wdata, jump_addr, wd, tgt);
            bad++;
        end
        tally(bad);
    endtask

    initial begin
        logic [7:0][31:0] c;
        logic [31:0]      w;
        logic [31:0]      a;
        logic [31:0]      b;
        logic [31:0]      p;
        logic [31:0]      exp_wd;
        logic [31:0]      exp_tgt;
        logic             exp_we;
        logic             exp_jump;
        int               op;
        int               k;
        seed        = 94;
        pass_cnt    = 0;
        fail_cnt    = 0;
        test_checks = 0;
        test_fail   = 0;
        drive(1'b1, 32'h100000ef, 32'h00002000, 32'h0, 32'h0);   // valid jal held in reset
        load_cases();
        loaded = 1'b1;

        // still at reset values although valid was high at every edge
        wait (rst_n === 1'b1);
        check_idle("reset", 32'h0, 32'h0);
        end_test("reset");

        for (k = 0; k < case_q.size(); k++) begin
            c = case_q[k];
            drive(1'b1, c[7], c[6], c[5], c[4]);
            @(posedge clk);
            #1;
            check_out($sformatf("case %0d (%h)", k + 1, c[7]), c[3][0], c[2], c[1][0], c[0]);
        end
        end_test("directed");

        // a jal word with valid low must change nothing
        exp_wd  = rd_wdata;
        exp_tgt = jump_addr;
        drive(1'b0, 32'h100000ef, 32'h00002000, 32'h0, 32'h0);
        @(posedge clk);
        #1;
        check_idle("idle", exp_wd, exp_tgt);
        end_test("idle");

        for (k = 0; k < RAND_CASES; k++) begin
            op       = {$random(seed)} % 6;
            a        = $random(seed);
            b        = $random(seed);
            p        = $random(seed) & 32'hffff_fffc;
            exp_we   = 1'b1;
            exp_jump = 1'b0;
            exp_tgt  = 32'h0;
            if (op >= 4 && $random(seed) & 1) begin
                b = a;                      // make equal operands likely
            end
            case (op)
                0: begin
                    w      = 32'h002081b3;
                    exp_wd = a + b;
                end
                1: begin
                    w      = 32'h402081b3;
                    exp_wd = a - b;
                end
                2: begin
                    w      = 32'h0020c1b3;
                    exp_wd = a ^ b;
                end
                3: begin
                    w      = 32'h0020b1b3;
                    exp_wd = {31'b0, a < b};
                end
                4: begin
                    w        = 32'h00208863;
                    exp_we   = 1'b0;
                    exp_jump = a == b;
                end
                default: begin
                    w        = 32'h00209863;
                    exp_we   = 1'b0;
                    exp_jump = a != b;
                end
            endcase
            if (op >= 4) begin
                exp_wd  = 32'h0;
                exp_tgt = p + 32'd16;       // both branch words use offset +16
            end
            drive(1'b1, w, p, a, b);
            @(posedge clk);
            #1;
            check_out($sformatf("random %0d (%h)", k + 1, w), exp_we, exp_wd, exp_jump, exp_tgt);
        end
        drive(1'b0, 32'h0, 32'h0, 32'h0, 32'h0);
        end_test("random");

        $display("checks passed: %0d, failed: %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    initial begin
        wait (loaded === 1'b1);
        #((case_q.size() + RAND_CASES + 20) * CLK_NS);
        $display("Timed out: the tests did not finish in the expected number of cycles");
        $display("Some tests failed");
        $finish;
    end

endmodule

/* sim/clk_gen.sv */
// Clock and reset source for the execute stage testbench.
// Holds the active-low reset for RST_CYCLES rising edges, then releases
// it shortly after an edge so the DUT never sees it move on a clock edge.

`timescale 1ns/1ps

module clk_gen #(
    parameter int PERIOD_NS  = 8,
    parameter int RST_CYCLES = 5
) (
    output logic clk,
    output logic rst_n_o
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        #1 rst_n_o = 1'b1;
    end

endmodule

/* logic/ex_stage.sv */
// Execute stage of a small RV32I core.
// Takes one instruction per cycle with its pc and source register values,
// marked by inst_valid_i, and presents write-back and jump results one
// cycle later. No back-pressure. Unknown opcodes and bad funct7 values
// pass through with no write and no jump.

`timescale 1ns/1ps

`include "rv_ex_consts.svh"

module ex_stage import rv_ex_pkg::*; (
    input  logic             clk,
    input  logic             rst_n_i,
    input  logic             inst_valid_i,
    input  logic [`XLEN-1:0] inst_i,
    input  logic [`XLEN-1:0] pc_i,
    input  logic [`XLEN-1:0] rs1_data_i,
    input  logic [`XLEN-1:0] rs2_data_i,
    output logic             ex_valid_o,
    output logic             rd_we_o,
    output logic [`XLEN-1:0] rd_wdata_o,
    output logic             jump_o,
    output logic [`XLEN-1:0] jump_addr_o
);

    rv_inst_u         inst;
    logic [6:0]       opcode;
    logic             is_op_imm;
    logic             is_op;
    logic             is_branch;
    logic             is_jal;
    logic             is_jalr;
    logic             is_lui;
    logic             is_auipc;
    logic             f7_ok;
    logic             we;
    logic [`XLEN-1:0] imm_i;
    logic [`XLEN-1:0] imm_u;
    logic [`XLEN-1:0] alu_b;
    logic [`XLEN-1:0] alu_res;
    logic [`XLEN-1:0] link_addr;
    logic [`XLEN-1:0] wdata;
    logic             br_take;
    logic [`XLEN-1:0] br_target;

    assign inst   = inst_i;
    assign opcode = inst.r.opcode;

    assign is_op_imm = opcode == `OPC_OP_IMM;
    assign is_op     = opcode == `OPC_OP;
    assign is_branch = opcode == `OPC_BRANCH;
    assign is_jal    = opcode == `OPC_JAL;
    assign is_jalr   = opcode == `OPC_JALR;
    assign is_lui    = opcode == `OPC_LUI;
    assign is_auipc  = opcode == `OPC_AUIPC;

    // mul group and anything else in funct7 is rejected
    assign f7_ok = (inst.r.funct7 == `F7_BASE) || (inst.r.funct7 == `F7_ALT);

    assign imm_i     = {{(`XLEN-12){inst.i.imm[11]}}, inst.i.imm};
    assign imm_u     = {inst.u.imm, 12'b0};
    assign alu_b     = is_op_imm ? imm_i : rs2_data_i;
    assign link_addr = pc_i + `XLEN'(`INST_BYTES);

    int_alu u_alu (
        .op_a_i     (rs1_data_i),
        .op_b_i     (alu_b),
        .funct3_i   (inst.r.funct3),
        .alt_i      (inst_i[30]),
        .imm_form_i (is_op_imm),
        .result_o   (alu_res)
    );

    branch_unit u_branch (
        .inst_i      (inst),
        .pc_i        (pc_i),
        .rs1_data_i  (rs1_data_i),
        .rs2_data_i  (rs2_data_i),
        .is_branch_i (is_branch),
        .is_jal_i    (is_jal),
        .is_jalr_i   (is_jalr),
        .take_o      (br_take),
        .target_o    (br_target)
    );

    assign we = is_op_imm | (is_op & f7_ok) | is_jal | is_jalr | is_lui | is_auipc;

    always_comb begin
        if (is_jal || is_jalr) begin
            wdata = link_addr;
        end else if (is_lui) begin
            wdata = imm_u;
        end else if (is_auipc) begin
            wdata = pc_i + imm_u;
        end else begin
            wdata = alu_res;            // op, op-imm, don't care otherwise
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ex_valid_o  <= 1'b0;
            rd_we_o     <= 1'b0;
            jump_o      <= 1'b0;
            rd_wdata_o  <= '0;
            jump_addr_o <= '0;
        end else begin
            ex_valid_o <= inst_valid_i;
            rd_we_o    <= inst_valid_i & we;
            jump_o     <= inst_valid_i & br_take;
            if (inst_valid_i) begin     // data holds on idle cycles
                rd_wdata_o  <= wdata;
                jump_addr_o <= br_target;
            end
        end
    end

endmodule

/* logic/branch_unit.sv */
// Branch and jump resolution for the execute stage.
// Evaluates the branch condition from funct3 and computes the target
// for branches, JAL and JALR. Kind flags come one-hot from the decoder.
// Purely combinational.

`timescale 1ns/1ps

`include "rv_ex_consts.svh"

module branch_unit import rv_ex_pkg::*; (
    input  rv_inst_u         inst_i,
    input  logic [`XLEN-1:0] pc_i,
    input  logic [`XLEN-1:0] rs1_data_i,
    input  logic [`XLEN-1:0] rs2_data_i,
    input  logic             is_branch_i,
    input  logic             is_jal_i,
    input  logic             is_jalr_i,
    output logic             take_o,
    output logic [`XLEN-1:0] target_o
);

    logic [`XLEN-1:0] b_off;
    logic [`XLEN-1:0] j_off;
    logic [`XLEN-1:0] i_off;
    logic [`XLEN-1:0] base;
    logic [`XLEN-1:0] offset;
    logic [`XLEN-1:0] sum;
    logic             eq;
    logic             lt_s;
    logic             lt_u;
    logic             cond;

    assign b_off = {{(`XLEN-13){inst_i.b.imm12}}, inst_i.b.imm12, inst_i.b.imm11,
                    inst_i.b.imm10_5, inst_i.b.imm4_1, 1'b0};
    assign j_off = {{(`XLEN-21){inst_i.j.imm20}}, inst_i.j.imm20, inst_i.j.imm19_12,
                    inst_i.j.imm11, inst_i.j.imm10_1, 1'b0};
    assign i_off = {{(`XLEN-12){inst_i.i.imm[11]}}, inst_i.i.imm};

    assign eq   = rs1_data_i == rs2_data_i;
    assign lt_s = $signed(rs1_data_i) < $signed(rs2_data_i);
    assign lt_u = rs1_data_i < rs2_data_i;

    always_comb begin
        case (inst_i.b.funct3)
            `F3_BEQ:  cond = eq;
            `F3_BNE:  cond = ~eq;
            `F3_BLT:  cond = lt_s;
            `F3_BGE:  cond = ~lt_s;
            `F3_BLTU: cond = lt_u;
            `F3_BGEU: cond = ~lt_u;
            default:  cond = 1'b0;      // 010, 011 not branches
        endcase
    end

    // one adder shared by all three kinds
    assign base   = is_jalr_i ? rs1_data_i : pc_i;
    assign offset = is_jalr_i ? i_off : (is_jal_i ? j_off : b_off);
    assign sum    = base + offset;

    assign target_o = {sum[`XLEN-1:1], sum[0] & ~is_jalr_i};  // jalr clears bit 0
    assign take_o   = (is_branch_i & cond) | is_jal_i | is_jalr_i;

endmodule

/* logic/int_alu.sv */
// Integer ALU of the execute stage.
// Serves both register-register and register-immediate operations.
// The caller passes the immediate already sign-extended on op_b_i and
// flags the immediate form, so bit 30 only means SUB for register ops.
// Purely combinational.

`timescale 1ns/1ps

`include "rv_ex_consts.svh"

module int_alu (
    input  logic [`XLEN-1:0] op_a_i,
    input  logic [`XLEN-1:0] op_b_i,
    input  logic [2:0]       funct3_i,
    input  logic             alt_i,       // instruction bit 30
    input  logic             imm_form_i,
    output logic [`XLEN-1:0] result_o
);

    logic [4:0]              shamt;
    logic                    sub_sel;
    logic [`XLEN-1:0]        add_res;
    logic [`XLEN-1:0]        srl_res;
    logic signed [`XLEN-1:0] sra_res;
    logic                    lt_s;
    logic                    lt_u;

    assign shamt   = op_b_i[4:0];           // only low five bits count
    assign sub_sel = alt_i & ~imm_form_i;   // addi imm may have bit 30 set

    assign add_res = sub_sel ? (op_a_i - op_b_i) : (op_a_i + op_b_i);

    // right shifts for the SR case
    assign srl_res = op_a_i >> shamt;
    assign sra_res = $signed(op_a_i) >>> shamt;

    assign lt_s = $signed(op_a_i) < $signed(op_b_i);
    assign lt_u = op_a_i < op_b_i;

    always_comb begin
        case (funct3_i)
            `F3_ADD: begin
                result_o = add_res;
            end
            `F3_SLL: begin
                result_o = op_a_i << shamt;
            end
            `F3_SLT: begin
                result_o = {{(`XLEN-1){1'b0}}, lt_s};
            end
            `F3_SLTU: begin
                result_o = {{(`XLEN-1){1'b0}}, lt_u};
            end
            `F3_XOR: begin
                result_o = op_a_i ^ op_b_i;
            end
            `F3_SR: begin
                if (alt_i) begin
                    result_o = sra_res;     // srai as well as sra
                end else begin
                    result_o = srl_res;
                end
            end
            `F3_OR: begin
                result_o = op_a_i | op_b_i;
            end
            `F3_AND: begin
                result_o = op_a_i & op_b_i;
            end
            default: begin
                result_o = '0;
            end
        endcase
    end

endmodule

/* logic/rv_ex_pkg.sv */
// Instruction word types for the execute stage.
// rv_inst_u overlays the R, I, B, U and J formats on one 32-bit word,
// so decode logic can name fields instead of slicing bit ranges.

`include "rv_ex_consts.svh"

package rv_ex_pkg;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rv_r_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } rv_i_t;

    // branch offset is scattered over the word
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } rv_b_t;

    typedef struct packed {
        logic [19:0] imm;     // bits 31:12 of the result
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } rv_u_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rv_j_t;

    typedef union packed {
        rv_r_t r;
        rv_i_t i;
        rv_b_t b;
        rv_u_t u;
        rv_j_t j;
    } rv_inst_u;

endpackage

/* logic/rv_ex_consts.svh */
// Shared constants for the RV32I execute stage.
// Include in every RTL file that needs the data width, the opcodes or
// the funct3/funct7 codes.

`ifndef RV_EX_CONSTS_SVH
`define RV_EX_CONSTS_SVH

`define XLEN        32          // data and address width
`define INST_BYTES  4           // link address step

// major opcodes that are kept
`define OPC_OP_IMM  7'b0010011
`define OPC_OP      7'b0110011
`define OPC_BRANCH  7'b1100011
`define OPC_JAL     7'b1101111
`define OPC_JALR    7'b1100111
`define OPC_LUI     7'b0110111
`define OPC_AUIPC   7'b0010111

// alu funct3
`define F3_ADD      3'b000
`define F3_SLL      3'b001
`define F3_SLT      3'b010
`define F3_SLTU     3'b011
`define F3_XOR      3'b100
`define F3_SR       3'b101      // srl / sra by bit 30
`define F3_OR       3'b110
`define F3_AND      3'b111

// branch funct3
`define F3_BEQ      3'b000
`define F3_BNE      3'b001
`define F3_BLT      3'b100
`define F3_BGE      3'b101
`define F3_BLTU     3'b110
`define F3_BGEU     3'b111

`define F7_BASE     7'b0000000
`define F7_ALT      7'b0100000  // sub, sra

`endif
